// File: Makefile
# Verilator build and run for the cpuCore testbench

VERILATOR ?= verilator
TOP       ?= cpuCore_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
cpuPkg.sv
controlDecoder.sv
regFile.sv
decodeStage.sv
executeStage.sv
resultStage.sv
cpuCore.sv
cpuCore_tb.sv

// File: controlDecoder.sv
// combinational control decoder from opcode and function code to the control word
`timescale 1ns/1ps

module controlDecoder (
    input  logic [5:0]    op,
    input  logic [5:0]    funct,
    output cpuPkg::ctrl_t ctrl
);

    always_comb begin
        // unknown encodings fall through with every enable low
        ctrl = '0;
        ctrl.aluOp = cpuPkg::ADD;
        case (op)
            cpuPkg::OP_SPECIAL: begin
                ctrl.regWrite = 1'b1;
                case (funct)
                    cpuPkg::FN_ADD, cpuPkg::FN_ADDU: ctrl.aluOp = cpuPkg::ADD;
                    cpuPkg::FN_SUB, cpuPkg::FN_SUBU: ctrl.aluOp = cpuPkg::SUB;
                    cpuPkg::FN_AND:  ctrl.aluOp = cpuPkg::AND;
                    cpuPkg::FN_OR:   ctrl.aluOp = cpuPkg::OR;
                    cpuPkg::FN_XOR:  ctrl.aluOp = cpuPkg::XOR;
                    cpuPkg::FN_NOR:  ctrl.aluOp = cpuPkg::NOR;
                    cpuPkg::FN_SLT:  ctrl.aluOp = cpuPkg::SLT;
                    cpuPkg::FN_SLTU: ctrl.aluOp = cpuPkg::SLTU;
                    cpuPkg::FN_SLL:  ctrl.aluOp = cpuPkg::SLL;
                    cpuPkg::FN_SRL:  ctrl.aluOp = cpuPkg::SRL;
                    cpuPkg::FN_SRA:  ctrl.aluOp = cpuPkg::SRA;
                    default:         ctrl.regWrite = 1'b0;
                endcase
            end
            cpuPkg::OP_SPECIAL2: begin
                if (funct == cpuPkg::FN_MUL) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp = cpuPkg::MUL;
                end
            end
            cpuPkg::OP_ADDI, cpuPkg::OP_ADDIU: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
            end
            cpuPkg::OP_SLTI, cpuPkg::OP_SLTIU: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.aluOp = (op == cpuPkg::OP_SLTI) ? cpuPkg::SLT : cpuPkg::SLTU;
            end
            cpuPkg::OP_ANDI, cpuPkg::OP_ORI, cpuPkg::OP_XORI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.zeroExt = 1'b1;
                case (op)
                    cpuPkg::OP_ANDI: ctrl.aluOp = cpuPkg::AND;
                    cpuPkg::OP_ORI:  ctrl.aluOp = cpuPkg::OR;
                    default:         ctrl.aluOp = cpuPkg::XOR;
                endcase
            end
            cpuPkg::OP_LUI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.luiSel = 1'b1;
                ctrl.aluOp = cpuPkg::LUI;
            end
            cpuPkg::OP_LW: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.aluSrc = 1'b1;
            end
            cpuPkg::OP_SW: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// File: cpuCore.sv
// core top: decode, execute and result stages with the shared stall
`timescale 1ns/1ps

module cpuCore (
    input  logic                      Clock,
    input  logic                      rst,
    input  logic                      instrValid,
    input  cpuPkg::instrWord_u        instr,
    input  logic                      ack,
    input  logic [cpuPkg::DATA_W-1:0] datRead,
    output logic                      instrReady,
    output cpuPkg::wbMaster_t         wbOut,
    output cpuPkg::retire_t           retire
);

    cpuPkg::decExe_t decExe;
    cpuPkg::exeRes_t exeRes;
    logic            stall;

    assign instrReady = !stall;

    decodeStage dec (
        .Clock      (Clock     ),
        .rst        (rst       ),
        .instrValid (instrValid),
        .instr      (instr     ),
        .stall      (stall     ),
        .retire     (retire    ),
        .decExe     (decExe    )
    );

    executeStage exe (
        .Clock  (Clock ),
        .rst    (rst   ),
        .stall  (stall ),
        .decExe (decExe),
        .exeRes (exeRes)
    );

    resultStage res (
        .Clock   (Clock  ),
        .rst     (rst    ),
        .exeRes  (exeRes ),
        .ack     (ack    ),
        .datRead (datRead),
        .wbOut   (wbOut  ),
        .stall   (stall  ),
        .retire  (retire )
    );

endmodule

// File: cpuCore_tb.sv
// testbench for cpuCore with clock, reset, instruction driver, Wishbone memory model and retire checker
`timescale 1ns/1ps

module cpuCore_tb;

    logic                      Clock = 1'b0;
    logic                      rst = 1'b1;
    logic                      instrValid = 1'b0;
    cpuPkg::instrWord_u        instr = '0;
    logic                      ack = 1'b0;
    logic [cpuPkg::DATA_W-1:0] datRead = '0;
    logic                      instrReady;
    cpuPkg::wbMaster_t         wbOut;
    cpuPkg::retire_t           retire;

    // word 0 is the test count and each test follows as four words
    // holding instruction, regWrite, destination register and data
    logic [31:0] testData [0:256];
    logic [31:0] dataMem [0:255];

    integer seed = 32'hcfb7;
    int     numTests;
    int     limit;
    int     cycles = 0;
    int     errors = 0;
    int     retireCount = 0;
    int     waitLeft = 0;
    logic   pending = 1'b0;

    cpuPkg::wbMaster_t busHeld;

    cpuCore DUT (
        .Clock      (Clock     ),
        .rst        (rst       ),
        .instrValid (instrValid),
        .instr      (instr     ),
        .ack        (ack       ),
        .datRead    (datRead   ),
        .instrReady (instrReady),
        .wbOut      (wbOut     ),
        .retire     (retire    )
    );

    always #10 Clock = ~Clock;

    always @(posedge Clock) begin
        if (!rst) cycles <= cycles + 1;
    end

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h (after %0d retires)",
                     name, actual, expected, retireCount);
            errors++;
        end
    endtask

    task automatic checkRetire();
        int base;
        base = 2 + 4 * retireCount;
        if (retireCount >= numTests) begin
            $display("retire seen after the last instruction had already retired");
            errors++;
        end else begin
            compareValue("retire.regWrite", {31'd0, retire.regWrite}, testData[base]);
            // address and data only matter when a register is written
            if (testData[base] != 0) begin
                compareValue("retire.addr", {27'd0, retire.addr}, testData[base + 1]);
                compareValue("retire.data", retire.data, testData[base + 2]);
            end
        end
        retireCount++;
    endtask

    // starts 1 ns after a rising edge and returns 1 ns after the accepting edge
    task automatic driveProgram();
        int k;
        for (k = 0; k < numTests; k++) begin
            instrValid = 1'b1;
            instr = testData[1 + 4 * k];
            while (!instrReady) begin
                @(posedge Clock);
                #1;
            end
            @(posedge Clock);
            #1;
        end
        instrValid = 1'b0;
        instr = '0;
    endtask

    // wishbone slave with 0 to 3 wait cycles and one word per 4 bytes
    always @(posedge Clock) begin : memModel
        int i;
        #1;
        if (rst) begin
            for (i = 0; i < 256; i++) begin
                dataMem[i] = '0;
            end
            ack = 1'b0;
            pending = 1'b0;
        end else if (ack) begin
            ack = 1'b0;
        end else if (wbOut.cyc && wbOut.stb) begin
            if (!pending) begin
                pending = 1'b1;
                busHeld = wbOut;
                waitLeft = $unsigned($random(seed)) % 4;
            end else begin
                // master holds its request until ack
                compareValue("wbOut.we", {31'd0, wbOut.we}, {31'd0, busHeld.we});
                compareValue("wbOut.adr", wbOut.adr, busHeld.adr);
                compareValue("wbOut.datWrite", wbOut.datWrite, busHeld.datWrite);
            end
            if (waitLeft == 0) begin
                if (wbOut.we) dataMem[wbOut.adr[9:2]] = wbOut.datWrite;
                datRead = dataMem[wbOut.adr[9:2]];
                ack = 1'b1;
                pending = 1'b0;
            end else begin
                waitLeft--;
            end
        end
    end

    always @(posedge Clock) begin
        #1;
        if (!rst && retire.valid) checkRetire();
    end

    initial begin
        $readmemh("cpuTests.mem", testData);
        numTests = testData[0];
        if (numTests <= 0) begin
            $display("no tests were read from the data file");
            errors++;
        end
        limit = 20 * numTests + 100;
        repeat (8) @(posedge Clock);
        #1;
        rst = 1'b0;
        fork
            driveProgram();
        join_none
        while (retireCount < numTests && cycles < limit) begin
            @(posedge Clock);
        end
        if (retireCount < numTests) begin
            $display("timeout after %0d cycles, only %0d of %0d instructions retired",
                     cycles, retireCount, numTests);
            errors++;
        end else begin
            // a few idle cycles to catch a stray retire
            repeat (4) @(posedge Clock);
        end
        $display("run finished: %0d errors, %0d of %0d instructions retired",
                 errors, retireCount, numTests);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: cpuPkg.sv
// shared widths, opcode and function codes, instruction union, ALU ops and stage structs
package cpuPkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL  = 6'h00;
    localparam logic [5:0] OP_SPECIAL2 = 6'h1c;
    localparam logic [5:0] OP_ADDI     = 6'h08;
    localparam logic [5:0] OP_ADDIU    = 6'h09;
    localparam logic [5:0] OP_SLTI     = 6'h0a;
    localparam logic [5:0] OP_SLTIU    = 6'h0b;
    localparam logic [5:0] OP_ANDI     = 6'h0c;
    localparam logic [5:0] OP_ORI      = 6'h0d;
    localparam logic [5:0] OP_XORI     = 6'h0e;
    localparam logic [5:0] OP_LUI      = 6'h0f;
    localparam logic [5:0] OP_LW       = 6'h23;
    localparam logic [5:0] OP_SW       = 6'h2b;

    // function codes, FN_MUL lives under SPECIAL2
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_MUL  = 6'h02;

    typedef struct packed {
        logic [5:0]            op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } rFields_t;

    typedef struct packed {
        logic [5:0]            op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm16;
    } iFields_t;

    // one instruction word seen as R-type or I-type
    typedef union packed {
        rFields_t r;
        iFields_t i;
    } instrWord_u;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, NOR, SLT, SLTU, SLL, SRL, SRA, MUL, LUI
    } aluOp_t;

    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   aluSrc;
        logic   zeroExt;
        logic   luiSel;
        aluOp_t aluOp;
    } ctrl_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [DATA_W-1:0]     rsData;
        logic [DATA_W-1:0]     rtData;
        logic [DATA_W-1:0]     imm;
        logic [4:0]            shamt;
        logic [REG_ADDR_W-1:0] destAddr;
    } decExe_t;

    typedef struct packed {
        logic                  valid;
        logic                  regWrite;
        logic                  memRead;
        logic                  memWrite;
        logic [REG_ADDR_W-1:0] destAddr;
        logic [DATA_W-1:0]     result;
        logic [DATA_W-1:0]     storeData;
    } exeRes_t;

    typedef struct packed {
        logic                  valid;
        logic                  regWrite;
        logic [REG_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     data;
    } retire_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [DATA_W-1:0] adr;
        logic [DATA_W-1:0] datWrite;
    } wbMaster_t;

endpackage

// File: cpuTests.mem
// first value is the number of tests, then one test per line
// columns: instruction word, expected regWrite, expected dest register, expected data
1c
20010064 1 01 00000064
2002fff9 1 02 fffffff9
3c031234 1 03 12340000
34048001 1 04 00008001
00222820 1 05 0000005d
00223022 1 06 0000006b
00443824 1 07 00008001
00644025 1 08 12348001
00224826 1 09 ffffff9d
00245027 1 0a ffff7f9a
0041582a 1 0b 00000001
0041602b 1 0c 00000000
304dff0f 1 0d 0000ff09
382effff 1 0e 0000ff9b
00017900 1 0f 00000640
00028102 1 10 0fffffff
00028843 1 11 fffffffc
70619002 1 12 1c500000
ac090010 0 00 00000000
8c130010 1 13 ffffff9d
ac320040 0 00 00000000
00220020 0 00 00000000
8c1400a4 1 14 1c500000
10220003 0 00 00000000
0013a825 1 15 ffffff9d
0001b021 1 16 00000064
0293b822 1 17 1c500063
2858fffa 1 18 00000001

// File: decodeStage.sv
// decode stage: control decode, register read, immediate forming, destination select
`timescale 1ns/1ps

module decodeStage (
    input  logic               Clock,
    input  logic               rst,
    input  logic               instrValid,
    input  cpuPkg::instrWord_u instr,
    input  logic               stall,
    input  cpuPkg::retire_t    retire,
    output cpuPkg::decExe_t    decExe
);

    cpuPkg::ctrl_t                     ctrl;
    cpuPkg::ctrl_t                     ctrlOut;
    logic [cpuPkg::DATA_W-1:0]         rsData;
    logic [cpuPkg::DATA_W-1:0]         rtData;
    logic [cpuPkg::DATA_W-1:0]         imm;
    logic [cpuPkg::REG_ADDR_W-1:0]     destAddr;
    logic                              rType;
    logic                              accept;

    assign accept = instrValid && !stall;

    controlDecoder ctrlDec (
        .op    (instr.r.op   ),
        .funct (instr.r.funct),
        .ctrl  (ctrl         )
    );

    regFile rf (
        .Clock  (Clock                         ),
        .rst    (rst                           ),
        .wrEn   (retire.valid && retire.regWrite),
        .wrAddr (retire.addr                   ),
        .wrData (retire.data                   ),
        .rsAddr (instr.r.rs                    ),
        .rtAddr (instr.i.rt                    ),
        .rsData (rsData                        ),
        .rtData (rtData                        )
    );

    always_comb begin
        if (ctrl.luiSel) imm = {instr.i.imm16, 16'd0};
        else if (ctrl.zeroExt) imm = {16'd0, instr.i.imm16};
        else imm = {{16{instr.i.imm16[15]}}, instr.i.imm16};
    end

    // R-type writes rd, everything else writes rt
    assign rType = (instr.r.op == cpuPkg::OP_SPECIAL) || (instr.r.op == cpuPkg::OP_SPECIAL2);
    assign destAddr = rType ? instr.r.rd : instr.i.rt;

    always_comb begin
        ctrlOut = ctrl;
        if (destAddr == '0) ctrlOut.regWrite = 1'b0;
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            decExe.valid <= 1'b0;
        end else if (!stall) begin
            decExe.valid <= instrValid;
        end
        if (accept) begin
            decExe.ctrl     <= ctrlOut;
            decExe.rsData   <= rsData;
            decExe.rtData   <= rtData;
            decExe.imm      <= imm;
            decExe.shamt    <= instr.r.shamt;
            decExe.destAddr <= destAddr;
        end
    end

endmodule

// File: executeStage.sv
// execute stage with operand select, ALU, shifter, multiplier and the execute pipeline register
`timescale 1ns/1ps

module executeStage (
    input  logic            Clock,
    input  logic            rst,
    input  logic            stall,
    input  cpuPkg::decExe_t decExe,
    output cpuPkg::exeRes_t exeRes
);

    logic [cpuPkg::DATA_W-1:0] opB;
    logic [cpuPkg::DATA_W-1:0] aluResult;

    assign opB = decExe.ctrl.aluSrc ? decExe.imm : decExe.rtData;

    always_comb begin
        case (decExe.ctrl.aluOp)
            cpuPkg::ADD:  aluResult = decExe.rsData + opB;
            cpuPkg::SUB:  aluResult = decExe.rsData - opB;
            cpuPkg::AND:  aluResult = decExe.rsData & opB;
            cpuPkg::OR:   aluResult = decExe.rsData | opB;
            cpuPkg::XOR:  aluResult = decExe.rsData ^ opB;
            cpuPkg::NOR:  aluResult = ~(decExe.rsData | opB);
            cpuPkg::SLT: begin
                aluResult = {{(cpuPkg::DATA_W-1){1'b0}},
                             $signed(decExe.rsData) < $signed(opB)};
            end
            cpuPkg::SLTU: begin
                aluResult = {{(cpuPkg::DATA_W-1){1'b0}}, decExe.rsData < opB};
            end
            // shifts act on rt by shamt
            cpuPkg::SLL:  aluResult = opB << decExe.shamt;
            cpuPkg::SRL:  aluResult = opB >> decExe.shamt;
            cpuPkg::SRA:  aluResult = $signed(opB) >>> decExe.shamt;
            // low word of the product only
            cpuPkg::MUL:  aluResult = decExe.rsData * opB;
            cpuPkg::LUI:  aluResult = opB;
            default:      aluResult = decExe.rsData + opB;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            exeRes.valid <= 1'b0;
        end else if (!stall) begin
            exeRes.valid <= decExe.valid;
        end
        if (!stall && decExe.valid) begin
            exeRes.regWrite  <= decExe.ctrl.regWrite;
            exeRes.memRead   <= decExe.ctrl.memRead;
            exeRes.memWrite  <= decExe.ctrl.memWrite;
            exeRes.destAddr  <= decExe.destAddr;
            // address for lw/sw and value for everything else
            exeRes.result    <= aluResult;
            exeRes.storeData <= decExe.rtData;
        end
    end

    // the decode entry feeding the ALU must not move under a bus cycle
    assert property (@(posedge Clock) disable iff (rst) stall |=> $stable(decExe));

endmodule

// File: regFile.sv
// 32x32 register file, two read ports with write-through, one write port
`timescale 1ns/1ps

module regFile (
    input  logic                              Clock,
    input  logic                              rst,
    input  logic                              wrEn,
    input  logic [cpuPkg::REG_ADDR_W-1:0]     wrAddr,
    input  logic [cpuPkg::DATA_W-1:0]         wrData,
    input  logic [cpuPkg::REG_ADDR_W-1:0]     rsAddr,
    input  logic [cpuPkg::REG_ADDR_W-1:0]     rtAddr,
    output logic [cpuPkg::DATA_W-1:0]         rsData,
    output logic [cpuPkg::DATA_W-1:0]         rtData
);

    logic [cpuPkg::DATA_W-1:0] regs [0:(1 << cpuPkg::REG_ADDR_W) - 1];

    function automatic logic [cpuPkg::DATA_W-1:0] readPort(
        input logic [cpuPkg::REG_ADDR_W-1:0] addr
    );
        if (addr == '0) return '0;
        // same-cycle write is forwarded to the reader
        if (wrEn && wrAddr == addr) return wrData;
        return regs[addr];
    endfunction

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < (1 << cpuPkg::REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    always_comb rsData = readPort(rsAddr);
    always_comb rtData = readPort(rtAddr);

    // decode drops regWrite for $0, so no retire should ever target it
    assert property (@(posedge Clock) disable iff (rst) wrEn |-> wrAddr != '0);

endmodule

// File: resultStage.sv
// result stage with the Wishbone classic master for lw/sw, writeback and retire
`timescale 1ns/1ps

module resultStage (
    input  logic                      Clock,
    input  logic                      rst,
    input  cpuPkg::exeRes_t           exeRes,
    input  logic                      ack,
    input  logic [cpuPkg::DATA_W-1:0] datRead,
    output cpuPkg::wbMaster_t         wbOut,
    output logic                      stall,
    output cpuPkg::retire_t           retire
);

    typedef enum logic {
        IDLE,
        BUSY
    } state_t;

    state_t                            state;
    logic                              isMem;
    logic                              pendWrite;
    logic [cpuPkg::REG_ADDR_W-1:0]     pendDest;

    assign isMem = exeRes.valid && (exeRes.memRead || exeRes.memWrite);

    // earlier stages freeze for the whole bus cycle including the ack cycle
    assign stall = (state == BUSY);

    always_ff @(posedge Clock) begin
        if (rst) begin
            state        <= IDLE;
            wbOut.cyc    <= 1'b0;
            wbOut.stb    <= 1'b0;
            retire.valid <= 1'b0;
        end else if (state == IDLE) begin
            retire.valid <= exeRes.valid && !isMem;
            if (isMem) begin
                state     <= BUSY;
                wbOut.cyc <= 1'b1;
                wbOut.stb <= 1'b1;
            end
        end else begin
            retire.valid <= ack;
            if (ack) begin
                state     <= IDLE;
                wbOut.cyc <= 1'b0;
                wbOut.stb <= 1'b0;
            end
        end

        if (state == IDLE) begin
            // bus fields only load here and hold until ack
            if (isMem) begin
                wbOut.we       <= exeRes.memWrite;
                wbOut.adr      <= exeRes.result;
                wbOut.datWrite <= exeRes.storeData;
                pendWrite      <= exeRes.regWrite && exeRes.memRead;
                pendDest       <= exeRes.destAddr;
            end
            retire.regWrite <= exeRes.regWrite;
            retire.addr     <= exeRes.destAddr;
            retire.data     <= exeRes.result;
        end else if (ack) begin
            // store retires with regWrite low
            retire.regWrite <= pendWrite;
            retire.addr     <= pendDest;
            retire.data     <= datRead;
        end
    end

    // the next entry waits in exeRes for the whole bus cycle
    assert property (@(posedge Clock) disable iff (rst) stall |=> $stable(exeRes));

    // slave may only answer an open cycle
    assert property (@(posedge Clock) disable iff (rst) ack |-> wbOut.cyc);

endmodule
